//--- hw/ex_pkg.sv
`default_nettype none

package ex_pkg;

    localparam int DATA_W           = 32;
    localparam int REG_ADDR_W       = 5;
    localparam int EXC_W            = 32;
    localparam int EXC_OVERFLOW_BIT = 29;

    typedef logic [DATA_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [7:0]            aluop_t;

    localparam reg_addr_t LINK_REG    = 5'd31;
    localparam word_t     LINK_OFFSET = 32'd8;  // Past the delay slot.

    localparam aluop_t ALUOP_NOP    = 8'h00;
    localparam aluop_t ALUOP_ADD    = 8'h01;
    localparam aluop_t ALUOP_ADDI   = 8'h02;
    localparam aluop_t ALUOP_ADDU   = 8'h03;
    localparam aluop_t ALUOP_ADDIU  = 8'h04;
    localparam aluop_t ALUOP_SUB    = 8'h05;
    localparam aluop_t ALUOP_SUBU   = 8'h06;
    localparam aluop_t ALUOP_SLT    = 8'h07;
    localparam aluop_t ALUOP_SLTI   = 8'h08;
    localparam aluop_t ALUOP_SLTU   = 8'h09;
    localparam aluop_t ALUOP_SLTIU  = 8'h0a;
    localparam aluop_t ALUOP_AND    = 8'h10;
    localparam aluop_t ALUOP_ANDI   = 8'h11;
    localparam aluop_t ALUOP_LUI    = 8'h12;
    localparam aluop_t ALUOP_NOR    = 8'h13;
    localparam aluop_t ALUOP_OR     = 8'h14;
    localparam aluop_t ALUOP_ORI    = 8'h15;
    localparam aluop_t ALUOP_XOR    = 8'h16;
    localparam aluop_t ALUOP_XORI   = 8'h17;
    localparam aluop_t ALUOP_SLL    = 8'h20;
    localparam aluop_t ALUOP_SLLV   = 8'h21;
    localparam aluop_t ALUOP_SRA    = 8'h22;
    localparam aluop_t ALUOP_SRAV   = 8'h23;
    localparam aluop_t ALUOP_SRL    = 8'h24;
    localparam aluop_t ALUOP_SRLV   = 8'h25;
    localparam aluop_t ALUOP_JAL    = 8'h30;
    localparam aluop_t ALUOP_JALR   = 8'h31;
    localparam aluop_t ALUOP_BGEZAL = 8'h32;
    localparam aluop_t ALUOP_BLTZAL = 8'h33;
    localparam aluop_t ALUOP_MFHI   = 8'h40;
    localparam aluop_t ALUOP_MFLO   = 8'h41;
    localparam aluop_t ALUOP_MTHI   = 8'h42;
    localparam aluop_t ALUOP_MTLO   = 8'h43;
    localparam aluop_t ALUOP_MULT   = 8'h44;
    localparam aluop_t ALUOP_MULTU  = 8'h45;
    localparam aluop_t ALUOP_LB     = 8'h50;
    localparam aluop_t ALUOP_LBU    = 8'h51;
    localparam aluop_t ALUOP_LH     = 8'h52;
    localparam aluop_t ALUOP_LHU    = 8'h53;
    localparam aluop_t ALUOP_LW     = 8'h54;
    localparam aluop_t ALUOP_SB     = 8'h58;
    localparam aluop_t ALUOP_SH     = 8'h59;
    localparam aluop_t ALUOP_SW     = 8'h5a;

    typedef struct packed {
        logic regfile_we;
        logic ram_we;
        logic hi_we;
        logic lo_we;
        logic mem_to_reg;
        logic in_delayslot;
    } ex_ctrl_t;

    typedef struct packed {
        word_t             pc;
        aluop_t            aluop;
        word_t             rs_data;
        word_t             rt_data;
        logic [15:0]       imm16;
        logic [4:0]        shamt;
        reg_addr_t         rd_addr;
        ex_ctrl_t          ctrl;
        logic [EXC_W-1:0]  exc;
    } ex_in_t;

    // HI/LO write from a later stage.
    typedef struct packed {
        logic  hi_we;
        word_t hi_data;
        logic  lo_we;
        word_t lo_data;
    } hilo_bypass_t;

    typedef struct packed {
        word_t             pc;
        aluop_t            aluop;
        ex_ctrl_t          ctrl;
        reg_addr_t         rd_addr;
        word_t             alu_data;
        word_t             ram_wdata;
        word_t             hi_wdata;
        word_t             lo_wdata;
        logic [EXC_W-1:0]  exc;
    } ex_out_t;

endpackage

`default_nettype wire

//--- hw/ex_hilo_forward.sv
`timescale 1ns/100ps
`default_nettype none

module ex_hilo_forward (
    input  ex_pkg::word_t        hilo_data_i,
    input  logic                 read_hi_i,
    input  ex_pkg::hilo_bypass_t mem_bypass_i,
    input  ex_pkg::hilo_bypass_t wb_bypass_i,
    output ex_pkg::word_t        hilo_fwd_o
);

    // Memory stage is younger, so it wins over writeback.
    always_comb begin
        if (read_hi_i) begin
            if (mem_bypass_i.hi_we) begin
                hilo_fwd_o = mem_bypass_i.hi_data;
            end else if (wb_bypass_i.hi_we) begin
                hilo_fwd_o = wb_bypass_i.hi_data;
            end else begin
                hilo_fwd_o = hilo_data_i;
            end
        end else begin
            if (mem_bypass_i.lo_we) begin
                hilo_fwd_o = mem_bypass_i.lo_data;
            end else if (wb_bypass_i.lo_we) begin
                hilo_fwd_o = wb_bypass_i.lo_data;
            end else begin
                hilo_fwd_o = hilo_data_i;  // Register file.
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/ex_alu.sv
`timescale 1ns/100ps
`default_nettype none

module ex_alu (
    input  ex_pkg::ex_in_t ex_in_i,
    input  ex_pkg::word_t  hilo_fwd_i,
    output ex_pkg::word_t  result_o,
    output logic           overflow_o
);

    import ex_pkg::*;

    word_t sign_imm;
    word_t zero_imm;
    word_t lui_imm;
    word_t rs;
    word_t rt;
    word_t add_res;
    word_t addi_res;
    word_t sub_res;
    logic  slt;
    logic  slti;
    logic  sltu;
    logic  sltiu;
    logic  ovf_add;
    logic  ovf_addi;
    logic  ovf_sub;

    assign rs       = ex_in_i.rs_data;
    assign rt       = ex_in_i.rt_data;
    assign sign_imm = {{(DATA_W-16){ex_in_i.imm16[15]}}, ex_in_i.imm16};
    assign zero_imm = {{(DATA_W-16){1'b0}}, ex_in_i.imm16};
    assign lui_imm  = {ex_in_i.imm16, {(DATA_W-16){1'b0}}};

    assign add_res  = rs + rt;
    assign addi_res = rs + sign_imm;  // Also the load/store address.
    assign sub_res  = rs - rt;

    assign slt   = $signed(rs) < $signed(rt);
    assign slti  = $signed(rs) < $signed(sign_imm);
    assign sltu  = rs < rt;
    assign sltiu = rs < sign_imm;

    // Same-sign operands with a flipped result sign.
    assign ovf_add  = (rs[DATA_W-1] == rt[DATA_W-1]) && (add_res[DATA_W-1] != rs[DATA_W-1]);
    assign ovf_addi = (rs[DATA_W-1] == sign_imm[DATA_W-1])
                   && (addi_res[DATA_W-1] != rs[DATA_W-1]);
    assign ovf_sub  = (rs[DATA_W-1] != rt[DATA_W-1]) && (sub_res[DATA_W-1] != rs[DATA_W-1]);

    always_comb begin
        case (ex_in_i.aluop)
            ALUOP_ADD:    overflow_o = ovf_add;
            ALUOP_ADDI:   overflow_o = ovf_addi;
            ALUOP_SUB:    overflow_o = ovf_sub;
            default:      overflow_o = 1'b0;
        endcase
    end

    always_comb begin
        case (ex_in_i.aluop)
            ALUOP_NOP:                  result_o = '0;
            ALUOP_ADD, ALUOP_ADDU:      result_o = add_res;
            ALUOP_ADDI, ALUOP_ADDIU:    result_o = addi_res;
            ALUOP_SUB, ALUOP_SUBU:      result_o = sub_res;
            ALUOP_SLT:                  result_o = {{(DATA_W-1){1'b0}}, slt};
            ALUOP_SLTI:                 result_o = {{(DATA_W-1){1'b0}}, slti};
            ALUOP_SLTU:                 result_o = {{(DATA_W-1){1'b0}}, sltu};
            ALUOP_SLTIU:                result_o = {{(DATA_W-1){1'b0}}, sltiu};
            ALUOP_AND:                  result_o = rs & rt;
            ALUOP_ANDI:                 result_o = rs & zero_imm;
            ALUOP_LUI:                  result_o = lui_imm;
            ALUOP_NOR:                  result_o = ~(rs | rt);
            ALUOP_OR:                   result_o = rs | rt;
            ALUOP_ORI:                  result_o = rs | zero_imm;
            ALUOP_XOR:                  result_o = rs ^ rt;
            ALUOP_XORI:                 result_o = rs ^ zero_imm;
            ALUOP_SLL:                  result_o = rt << ex_in_i.shamt;
            ALUOP_SLLV:                 result_o = rt << rs[4:0];
            ALUOP_SRA:                  result_o = word_t'($signed(rt) >>> ex_in_i.shamt);
            ALUOP_SRAV:                 result_o = word_t'($signed(rt) >>> rs[4:0]);
            ALUOP_SRL:                  result_o = rt >> ex_in_i.shamt;
            ALUOP_SRLV:                 result_o = rt >> rs[4:0];
            ALUOP_JAL, ALUOP_JALR,
            ALUOP_BGEZAL, ALUOP_BLTZAL: result_o = ex_in_i.pc + LINK_OFFSET;
            ALUOP_MFHI, ALUOP_MFLO:     result_o = hilo_fwd_i;
            ALUOP_LB, ALUOP_LBU,
            ALUOP_LH, ALUOP_LHU,
            ALUOP_LW, ALUOP_SB,
            ALUOP_SH, ALUOP_SW:         result_o = addi_res;
            default:                    result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/ex_hilo_write.sv
`timescale 1ns/100ps
`default_nettype none

module ex_hilo_write (
    input  ex_pkg::aluop_t               aluop_i,
    input  ex_pkg::word_t                rs_i,
    input  ex_pkg::word_t                rt_i,
    output logic [2*ex_pkg::DATA_W-1:0]  hilo_wdata_o
);

    import ex_pkg::*;

    logic signed [2*DATA_W-1:0] prod_s;
    logic        [2*DATA_W-1:0] prod_u;

    assign prod_s = $signed(rs_i) * $signed(rt_i);
    assign prod_u = {{DATA_W{1'b0}}, rs_i} * {{DATA_W{1'b0}}, rt_i};

    always_comb begin
        case (aluop_i)
            ALUOP_MULT: begin
                hilo_wdata_o = prod_s;
            end
            ALUOP_MULTU: begin
                hilo_wdata_o = prod_u;
            end
            ALUOP_MTHI, ALUOP_MTLO: begin
                hilo_wdata_o = {rs_i, rs_i};  // Enables pick the half.
            end
            default: begin
                hilo_wdata_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hw/ex_result_reg.sv
`timescale 1ns/100ps
`default_nettype none

module ex_result_reg (
    input  logic                         clk,
    input  logic                         rst_i,
    input  ex_pkg::ex_in_t               ex_in_i,
    input  ex_pkg::word_t                alu_result_i,
    input  logic                         overflow_i,
    input  logic [2*ex_pkg::DATA_W-1:0]  hilo_wdata_i,
    output ex_pkg::ex_out_t              ex_out_o
);

    import ex_pkg::*;

    reg_addr_t        rd_addr_next;
    logic [EXC_W-1:0] exc_next;

    always_comb begin
        if (overflow_i) begin
            rd_addr_next = '0;  // Trapped result goes nowhere.
        end else if (ex_in_i.aluop == ALUOP_JAL
                  || ex_in_i.aluop == ALUOP_BGEZAL
                  || ex_in_i.aluop == ALUOP_BLTZAL) begin
            rd_addr_next = LINK_REG;
        end else begin
            rd_addr_next = ex_in_i.rd_addr;  // JALR names its own rd.
        end
    end

    always_comb begin
        exc_next                   = ex_in_i.exc;
        exc_next[EXC_OVERFLOW_BIT] = overflow_i;
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ex_out_o <= '0;
        end else begin
            ex_out_o.pc        <= ex_in_i.pc;
            ex_out_o.aluop     <= ex_in_i.aluop;
            ex_out_o.ctrl      <= ex_in_i.ctrl;
            ex_out_o.rd_addr   <= rd_addr_next;
            ex_out_o.alu_data  <= alu_result_i;
            ex_out_o.ram_wdata <= ex_in_i.rt_data;  // Store data.
            ex_out_o.hi_wdata  <= hilo_wdata_i[2*DATA_W-1:DATA_W];
            ex_out_o.lo_wdata  <= hilo_wdata_i[DATA_W-1:0];
            ex_out_o.exc       <= exc_next;
        end
    end

    reset_clears_ctrl: assert property (
        @(posedge clk) rst_i |=> (ex_out_o.ctrl == '0)
    );

    // A trapped instruction never targets a live register.
    overflow_kills_write: assert property (
        @(posedge clk) disable iff (rst_i)
        ex_out_o.exc[EXC_OVERFLOW_BIT] |-> (ex_out_o.rd_addr == '0)
    );

endmodule

`default_nettype wire

//--- hw/ex_stage.sv
`timescale 1ns/100ps
`default_nettype none

module ex_stage (
    input  logic                 clk,
    input  logic                 rst_i,
    input  ex_pkg::ex_in_t       ex_in_i,
    input  ex_pkg::word_t        hilo_data_i,
    input  logic                 hilo_read_hi_i,
    input  ex_pkg::hilo_bypass_t mem_bypass_i,
    input  ex_pkg::hilo_bypass_t wb_bypass_i,
    output ex_pkg::ex_out_t      ex_out_o
);

    import ex_pkg::*;

    word_t                 hilo_fwd;
    word_t                 alu_result;
    logic                  overflow;
    logic [2*DATA_W-1:0]   hilo_wdata;

    ex_hilo_forward ex_hilo_forward_inst (
        .hilo_data_i  (hilo_data_i),
        .read_hi_i    (hilo_read_hi_i),
        .mem_bypass_i (mem_bypass_i),
        .wb_bypass_i  (wb_bypass_i),
        .hilo_fwd_o   (hilo_fwd)
    );

    ex_alu ex_alu_inst (
        .ex_in_i    (ex_in_i),
        .hilo_fwd_i (hilo_fwd),
        .result_o   (alu_result),
        .overflow_o (overflow)
    );

    ex_hilo_write ex_hilo_write_inst (
        .aluop_i      (ex_in_i.aluop),
        .rs_i         (ex_in_i.rs_data),
        .rt_i         (ex_in_i.rt_data),
        .hilo_wdata_o (hilo_wdata)
    );

    // Single register stage toward memory.
    ex_result_reg ex_result_reg_inst (
        .clk          (clk),
        .rst_i        (rst_i),
        .ex_in_i      (ex_in_i),
        .alu_result_i (alu_result),
        .overflow_i   (overflow),
        .hilo_wdata_i (hilo_wdata),
        .ex_out_o     (ex_out_o)
    );

endmodule

`default_nettype wire

//--- bench/tb_ex_model.svh
`ifndef TB_EX_MODEL_SVH
`define TB_EX_MODEL_SVH

function automatic word_t sign_extend16(input logic [15:0] imm);
    sign_extend16 = {{16{imm[15]}}, imm};
endfunction

// Signed overflow from a 33-bit sum or difference.
function automatic logic signed_overflow(input word_t a, input word_t b, input logic sub);
    logic [32:0] wide;
    if (sub) begin
        wide = {a[31], a} - {b[31], b};
    end else begin
        wide = {a[31], a} + {b[31], b};
    end
    signed_overflow = wide[32] != wide[31];
endfunction

function automatic word_t forward_hilo(input word_t rf, input logic read_hi,
                                       input hilo_bypass_t mem, input hilo_bypass_t wb);
    if (read_hi) begin
        forward_hilo = mem.hi_we ? mem.hi_data : (wb.hi_we ? wb.hi_data : rf);
    end else begin
        forward_hilo = mem.lo_we ? mem.lo_data : (wb.lo_we ? wb.lo_data : rf);
    end
endfunction

function automatic logic [63:0] expected_hilo(input ex_in_t v);
    logic signed [63:0] a;
    logic signed [63:0] b;
    a = {{32{v.rs_data[31]}}, v.rs_data};
    b = {{32{v.rt_data[31]}}, v.rt_data};
    case (v.aluop)
        ALUOP_MULT:             expected_hilo = a * b;
        ALUOP_MULTU:            expected_hilo = {32'h0, v.rs_data} * {32'h0, v.rt_data};
        ALUOP_MTHI, ALUOP_MTLO: expected_hilo = {v.rs_data, v.rs_data};
        default:                expected_hilo = 64'h0;
    endcase
endfunction

function automatic word_t expected_alu(input ex_in_t v, input word_t fwd);
    word_t simm;
    word_t zimm;
    word_t rs;
    word_t rt;
    rs   = v.rs_data;
    rt   = v.rt_data;
    simm = sign_extend16(v.imm16);
    zimm = {16'h0, v.imm16};
    case (v.aluop)
        ALUOP_ADD, ALUOP_ADDU:   expected_alu = rs + rt;
        ALUOP_ADDI, ALUOP_ADDIU: expected_alu = rs + simm;
        ALUOP_SUB, ALUOP_SUBU:   expected_alu = rs - rt;
        ALUOP_SLT:   expected_alu = ($signed(rs) < $signed(rt)) ? 32'd1 : 32'd0;
        ALUOP_SLTI:  expected_alu = ($signed(rs) < $signed(simm)) ? 32'd1 : 32'd0;
        ALUOP_SLTU:  expected_alu = (rs < rt) ? 32'd1 : 32'd0;
        ALUOP_SLTIU: expected_alu = (rs < simm) ? 32'd1 : 32'd0;
        ALUOP_AND:   expected_alu = rs & rt;
        ALUOP_ANDI:  expected_alu = rs & zimm;
        ALUOP_LUI:   expected_alu = {v.imm16, 16'h0};
        ALUOP_NOR:   expected_alu = ~(rs | rt);
        ALUOP_OR:    expected_alu = rs | rt;
        ALUOP_ORI:   expected_alu = rs | zimm;
        ALUOP_XOR:   expected_alu = rs ^ rt;
        ALUOP_XORI:  expected_alu = rs ^ zimm;
        ALUOP_SLL:   expected_alu = rt << v.shamt;
        ALUOP_SLLV:  expected_alu = rt << rs[4:0];
        ALUOP_SRL:   expected_alu = rt >> v.shamt;
        ALUOP_SRLV:  expected_alu = rt >> rs[4:0];
        // Logical shift with the sign filled in from the top.
        ALUOP_SRA:   expected_alu = (rt >> v.shamt) | (rt[31] ? ~(32'hffff_ffff >> v.shamt) : 0);
        ALUOP_SRAV:  expected_alu = (rt >> rs[4:0]) | (rt[31] ? ~(32'hffff_ffff >> rs[4:0]) : 0);
        ALUOP_JAL, ALUOP_JALR, ALUOP_BGEZAL, ALUOP_BLTZAL: expected_alu = v.pc + 32'd8;
        ALUOP_MFHI, ALUOP_MFLO: expected_alu = fwd;
        ALUOP_LB, ALUOP_LBU, ALUOP_LH, ALUOP_LHU, ALUOP_LW,
        ALUOP_SB, ALUOP_SH, ALUOP_SW: expected_alu = rs + simm;
        default:     expected_alu = 32'h0;
    endcase
endfunction

function automatic ex_out_t expected_out(input ex_in_t v, input word_t fwd);
    ex_out_t     r;
    logic        ovf;
    logic [63:0] hilo;
    case (v.aluop)
        ALUOP_ADD:  ovf = signed_overflow(v.rs_data, v.rt_data, 1'b0);
        ALUOP_ADDI: ovf = signed_overflow(v.rs_data, sign_extend16(v.imm16), 1'b0);
        ALUOP_SUB:  ovf = signed_overflow(v.rs_data, v.rt_data, 1'b1);
        default:    ovf = 1'b0;
    endcase
    hilo        = expected_hilo(v);
    r.pc        = v.pc;
    r.aluop     = v.aluop;
    r.ctrl      = v.ctrl;
    r.alu_data  = expected_alu(v, fwd);
    r.ram_wdata = v.rt_data;
    r.hi_wdata  = hilo[63:32];
    r.lo_wdata  = hilo[31:0];
    r.exc       = v.exc;
    r.exc[29]   = ovf;
    if (ovf) begin
        r.rd_addr = 5'd0;
    end else if (v.aluop == ALUOP_JAL || v.aluop == ALUOP_BGEZAL
              || v.aluop == ALUOP_BLTZAL) begin
        r.rd_addr = 5'd31;
    end else begin
        r.rd_addr = v.rd_addr;
    end
    return r;
endfunction

`endif

//--- bench/tb_ex_stage.sv
`timescale 1ns/100ps
`default_nettype none

module tb_ex_stage;

    import ex_pkg::*;

    `include "tb_ex_model.svh"

    localparam int NUM_VECTORS = 2000;
    localparam int CYCLE_LIMIT = NUM_VECTORS + 50;
    localparam int NUM_OPS     = 43;

    logic         clk;
    logic         rst_i;
    ex_in_t       ex_in;
    word_t        hilo_data;
    logic         hilo_read_hi;
    hilo_bypass_t mem_bypass;
    hilo_bypass_t wb_bypass;
    ex_out_t      ex_out;
    ex_out_t      expected;
    aluop_t       op_list [NUM_OPS];
    integer       seed;
    int           cycles = 0;

    ex_stage ex_stage_inst (
        .clk            (clk),
        .rst_i          (rst_i),
        .ex_in_i        (ex_in),
        .hilo_data_i    (hilo_data),
        .hilo_read_hi_i (hilo_read_hi),
        .mem_bypass_i   (mem_bypass),
        .wb_bypass_i    (wb_bypass),
        .ex_out_o       (ex_out)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("TB FAILED");
            $fatal(1, "Timeout: no verdict after %0d cycles.", CYCLE_LIMIT);
        end
    end

    task automatic check_value(input string name, input logic [255:0] exp_v,
                               input logic [255:0] act_v);
        if (exp_v !== act_v) begin
            $display("[ERROR] %s: expected %0h, actual %0h", name, exp_v, act_v);
            $display("TB FAILED");
            $fatal(1, "Output mismatch on %s.", name);
        end
    endtask

    // Sign-boundary corners mixed with plain random words.
    task automatic draw_operand(output word_t w);
        int pick;
        pick = $unsigned($random(seed)) % 8;
        case (pick)
            0:       w = 32'h7fff_ffff;
            1:       w = 32'h8000_0000;
            2:       w = 32'hffff_ffff;
            3:       w = 32'h0000_0001;
            default: w = $random(seed);
        endcase
    endtask

    task automatic draw_vector();
        word_t       w;
        logic [31:0] r;
        ex_in.aluop = op_list[$unsigned($random(seed)) % NUM_OPS];
        draw_operand(w);
        ex_in.rs_data = w;
        draw_operand(w);
        ex_in.rt_data = w;
        r = $random(seed);
        ex_in.ctrl    = r[5:0];
        ex_in.rd_addr = r[10:6];
        ex_in.shamt   = r[15:11];
        ex_in.imm16   = r[31:16];
        r = $random(seed);
        ex_in.pc      = {r[31:2], 2'b00};
        ex_in.exc     = $random(seed);
        hilo_data     = $random(seed);
        r = $random(seed);
        hilo_read_hi       = r[0];
        mem_bypass.hi_we   = r[1];
        mem_bypass.lo_we   = r[2];
        wb_bypass.hi_we    = r[3];
        wb_bypass.lo_we    = r[4];
        mem_bypass.hi_data = $random(seed);
        mem_bypass.lo_data = $random(seed);
        wb_bypass.hi_data  = $random(seed);
        wb_bypass.lo_data  = $random(seed);
        expected = expected_out(ex_in, forward_hilo(hilo_data, hilo_read_hi,
                                                    mem_bypass, wb_bypass));
    endtask

    task automatic compare_output(input int idx);
        string tag;
        tag = $sformatf("vector %0d aluop %02h", idx, expected.aluop);
        check_value({tag, " pc"}, expected.pc, ex_out.pc);
        check_value({tag, " aluop"}, expected.aluop, ex_out.aluop);
        check_value({tag, " ctrl"}, expected.ctrl, ex_out.ctrl);
        check_value({tag, " rd_addr"}, expected.rd_addr, ex_out.rd_addr);
        check_value({tag, " alu_data"}, expected.alu_data, ex_out.alu_data);
        check_value({tag, " ram_wdata"}, expected.ram_wdata, ex_out.ram_wdata);
        check_value({tag, " hi_wdata"}, expected.hi_wdata, ex_out.hi_wdata);
        check_value({tag, " lo_wdata"}, expected.lo_wdata, ex_out.lo_wdata);
        check_value({tag, " exc"}, expected.exc, ex_out.exc);
    endtask

    initial begin
        seed         = 32'hf85a;
        rst_i        = 1'b1;
        ex_in        = '0;
        hilo_data    = '0;
        hilo_read_hi = 1'b0;
        mem_bypass   = '0;
        wb_bypass    = '0;
        expected     = '0;
        op_list = '{ALUOP_NOP, ALUOP_ADD, ALUOP_ADDI, ALUOP_ADDU, ALUOP_ADDIU, ALUOP_SUB,
                    ALUOP_SUBU, ALUOP_SLT, ALUOP_SLTI, ALUOP_SLTU, ALUOP_SLTIU, ALUOP_AND,
                    ALUOP_ANDI, ALUOP_LUI, ALUOP_NOR, ALUOP_OR, ALUOP_ORI, ALUOP_XOR,
                    ALUOP_XORI, ALUOP_SLL, ALUOP_SLLV, ALUOP_SRA, ALUOP_SRAV, ALUOP_SRL,
                    ALUOP_SRLV, ALUOP_JAL, ALUOP_JALR, ALUOP_BGEZAL, ALUOP_BLTZAL,
                    ALUOP_MFHI, ALUOP_MFLO, ALUOP_MTHI, ALUOP_MTLO, ALUOP_MULT,
                    ALUOP_MULTU, ALUOP_LB, ALUOP_LBU, ALUOP_LH, ALUOP_LHU, ALUOP_LW,
                    ALUOP_SB, ALUOP_SH, ALUOP_SW};
        draw_vector();  // Live inputs while reset is held.
        ex_in.ctrl = '1;
        repeat (5) @(posedge clk);
        #1;
        check_value("reset clears output", '0, ex_out);
        #1;
        rst_i = 1'b0;
        draw_vector();
        for (int i = 0; i < NUM_VECTORS; i++) begin
            @(posedge clk);
            #1;
            compare_output(i);  // Result of the vector driven last cycle.
            #1;
            draw_vector();
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+bench
hw/ex_pkg.sv
hw/ex_hilo_forward.sv
hw/ex_alu.sv
hw/ex_hilo_write.sv
hw/ex_result_reg.sv
hw/ex_stage.sv
bench/tb_ex_stage.sv

//--- Makefile
TOP = tb_ex_stage

.PHONY: build run clean

build:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
